// File: source/tile_pkg.sv
package tile_pkg;

  // ---------------------------------------------------------------------
  // Sizes
  // ---------------------------------------------------------------------
  localparam int XLEN       = 32;
  localparam int REG_NUM    = 16;
  localparam int REG_W      = 4;
  localparam int ROB_SIZE   = 8;
  localparam int ROB_ID_W   = 3;
  // Credit counter must reach ROB_SIZE itself
  localparam int ROB_CRED_W = ROB_ID_W + 1;

  // ---------------------------------------------------------------------
  // Encodings
  // ---------------------------------------------------------------------
  typedef enum logic [2:0] {
    OP_ADD = 3'd0,
    OP_SUB = 3'd1,
    OP_AND = 3'd2,
    OP_OR  = 3'd3,
    OP_XOR = 3'd4,
    OP_SLL = 3'd5,
    OP_MUL = 3'd6
  } op_e;

  typedef enum logic [1:0] {
    ENT_FREE = 2'd0,
    ENT_WAIT = 2'd1,
    ENT_DONE = 2'd2
  } rob_state_e;

  typedef enum logic {
    MUL_IDLE = 1'b0,
    MUL_RUN  = 1'b1
  } mul_state_e;

  // ---------------------------------------------------------------------
  // Buses
  // ---------------------------------------------------------------------
  typedef struct packed {
    op_e             op;
    logic [REG_W-1:0] rd;
    logic [REG_W-1:0] rs1;
    logic [REG_W-1:0] rs2;
    logic            use_imm;
    logic [XLEN-1:0] imm;
  } disp_inst_t;

  typedef struct packed {
    op_e                 op;
    logic [REG_W-1:0]    rd;
    logic [ROB_ID_W-1:0] rob_id;
    logic [XLEN-1:0]     opa;
    logic [XLEN-1:0]     opb;
  } issue_t;

  typedef struct packed {
    logic             valid;
    logic [REG_W-1:0] rd;
    logic [XLEN-1:0]  data;
  } phy_wr_t;

  typedef struct packed {
    logic                valid;
    logic [ROB_ID_W-1:0] rob_id;
    logic [XLEN-1:0]     data;
  } done_rpt_t;

  typedef struct packed {
    logic [REG_W-1:0] rd;
    logic [XLEN-1:0]  data;
  } commit_t;

endpackage

// File: source/tile_regfile.sv
`timescale 1ns/10ps

module tile_regfile (
  input  logic                        i_clk,
  input  logic                        i_arst_n,

  input  logic [tile_pkg::REG_W-1:0]  i_rd_addr_a,
  input  logic [tile_pkg::REG_W-1:0]  i_rd_addr_b,
  output logic [tile_pkg::XLEN-1:0]   o_rd_data_a,
  output logic [tile_pkg::XLEN-1:0]   o_rd_data_b,

  input  tile_pkg::phy_wr_t           i_wr0,
  input  tile_pkg::phy_wr_t           i_wr1
);

  import tile_pkg::*;

  logic [XLEN-1:0] r_regs [REG_NUM];

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int i = 0; i < REG_NUM; i++)
        r_regs[i] <= '0;
    end else begin
      // Writes to x0 are dropped
      if (i_wr0.valid && (i_wr0.rd != '0))
        r_regs[i_wr0.rd] <= i_wr0.data;
      if (i_wr1.valid && (i_wr1.rd != '0))
        r_regs[i_wr1.rd] <= i_wr1.data;
    end
  end

  assign o_rd_data_a = (i_rd_addr_a == '0) ? '0 : r_regs[i_rd_addr_a];
  assign o_rd_data_b = (i_rd_addr_b == '0) ? '0 : r_regs[i_rd_addr_b];

  // Busy table in dispatch keeps the two units on distinct targets
  a_no_wr_clash : assert property (@(posedge i_clk) disable iff (!i_arst_n)
    !(i_wr0.valid && i_wr1.valid && (i_wr0.rd == i_wr1.rd) && (i_wr0.rd != '0)))
    else $error("Both write ports target x%0d", i_wr0.rd);

endmodule

// File: source/tile_alu.sv
`timescale 1ns/10ps

module tile_alu (
  input  logic                 i_clk,
  input  logic                 i_arst_n,

  input  logic                 i_issue_valid,
  input  tile_pkg::issue_t     i_issue,

  output tile_pkg::phy_wr_t    o_wr,
  output tile_pkg::done_rpt_t  o_done
);

  import tile_pkg::*;

  logic                r_s1_valid;
  logic [REG_W-1:0]    r_s1_rd;
  logic [ROB_ID_W-1:0] r_s1_rob_id;
  logic [XLEN-1:0]     r_s1_data;

  logic                r_s2_valid;
  logic [REG_W-1:0]    r_s2_rd;
  logic [ROB_ID_W-1:0] r_s2_rob_id;
  logic [XLEN-1:0]     r_s2_data;

  function automatic logic [XLEN-1:0] alu_calc(op_e op, logic [XLEN-1:0] a,
                                                logic [XLEN-1:0] b);
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      OP_XOR:  return a ^ b;
      OP_SLL:  return a << b[4:0];
      // Multiplies never reach this unit
      default: return '0;
    endcase
  endfunction

  // ---------------------------------------------------------------------
  // Stage 1 result, stage 2 writeback
  // ---------------------------------------------------------------------
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      r_s1_valid <= 1'b0;
      r_s2_valid <= 1'b0;
    end else begin
      r_s1_valid <= i_issue_valid;
      r_s2_valid <= r_s1_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    r_s1_rd     <= i_issue.rd;
    r_s1_rob_id <= i_issue.rob_id;
    r_s1_data   <= alu_calc(i_issue.op, i_issue.opa, i_issue.opb);

    r_s2_rd     <= r_s1_rd;
    r_s2_rob_id <= r_s1_rob_id;
    r_s2_data   <= r_s1_data;
  end

  assign o_wr   = '{valid: r_s2_valid, rd: r_s2_rd, data: r_s2_data};
  assign o_done = '{valid: r_s2_valid, rob_id: r_s2_rob_id, data: r_s2_data};

endmodule

// File: source/tile_mul.sv
`timescale 1ns/10ps

module tile_mul (
  input  logic                 i_clk,
  input  logic                 i_arst_n,

  input  logic                 i_issue_valid,
  input  tile_pkg::issue_t     i_issue,

  output tile_pkg::phy_wr_t    o_wr,
  output tile_pkg::done_rpt_t  o_done,
  output logic                 o_credit_ret
);

  import tile_pkg::*;

  mul_state_e          r_state;
  logic                r_out_valid;
  logic [XLEN-1:0]     r_mcand;
  logic [XLEN-1:0]     r_mplier;
  logic [XLEN-1:0]     r_acc;
  logic [REG_W-1:0]    r_rd;
  logic [ROB_ID_W-1:0] r_rob_id;

  logic                w_start;
  logic                w_last;
  logic [XLEN-1:0]     w_acc_nxt;

  assign w_start   = (r_state == MUL_IDLE) & i_issue_valid;
  // Done once no set bits remain above the current one
  assign w_last    = (r_mplier[XLEN-1:1] == '0);
  assign w_acc_nxt = r_mplier[0] ? (r_acc + r_mcand) : r_acc;

  // ---------------------------------------------------------------------
  // FSM
  // ---------------------------------------------------------------------
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      r_state     <= MUL_IDLE;
      r_out_valid <= 1'b0;
    end else begin
      case (r_state)
        MUL_IDLE: if (i_issue_valid) r_state <= MUL_RUN;
        MUL_RUN:  if (w_last) r_state <= MUL_IDLE;
        default:  r_state <= MUL_IDLE;
      endcase
      r_out_valid <= (r_state == MUL_RUN) & w_last;
    end
  end

  // Shift-add datapath, low XLEN bits of the product
  always_ff @(posedge i_clk) begin
    if (w_start) begin
      r_mcand  <= i_issue.opa;
      r_mplier <= i_issue.opb;
      r_acc    <= '0;
      r_rd     <= i_issue.rd;
      r_rob_id <= i_issue.rob_id;
    end else if (r_state == MUL_RUN) begin
      r_acc    <= w_acc_nxt;
      r_mcand  <= r_mcand << 1;
      r_mplier <= r_mplier >> 1;
    end
  end

  // rd and rob_id hold until the credit is back
  assign o_wr         = '{valid: r_out_valid, rd: r_rd, data: r_acc};
  assign o_done       = '{valid: r_out_valid, rob_id: r_rob_id, data: r_acc};
  assign o_credit_ret = r_out_valid;

  a_no_issue_busy : assert property (@(posedge i_clk) disable iff (!i_arst_n)
    (r_state == MUL_RUN) |-> !i_issue_valid)
    else $error("Multiplier issued while running");

endmodule

// File: source/tile_rob.sv
`timescale 1ns/10ps

module tile_rob (
  input  logic                          i_clk,
  input  logic                          i_arst_n,

  input  logic                          i_alloc,
  input  logic [tile_pkg::REG_W-1:0]    i_alloc_rd,
  output logic [tile_pkg::ROB_ID_W-1:0] o_new_rob_id,

  input  tile_pkg::done_rpt_t           i_done0,
  input  tile_pkg::done_rpt_t           i_done1,

  output logic                          o_commit_valid,
  output tile_pkg::commit_t             o_commit
);

  import tile_pkg::*;

  logic [ROB_ID_W-1:0] r_head;
  logic [ROB_ID_W-1:0] r_tail;
  rob_state_e          r_state [ROB_SIZE];
  logic [REG_W-1:0]    r_rd    [ROB_SIZE];
  logic [XLEN-1:0]     r_data  [ROB_SIZE];

  // ---------------------------------------------------------------------
  // Head commit
  // ---------------------------------------------------------------------
  assign o_new_rob_id   = r_tail;
  assign o_commit_valid = (r_state[r_head] == ENT_DONE);
  assign o_commit       = '{rd: r_rd[r_head], data: r_data[r_head]};

  // ---------------------------------------------------------------------
  // Entry state and pointers
  // ---------------------------------------------------------------------
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      r_head <= '0;
      r_tail <= '0;
      for (int i = 0; i < ROB_SIZE; i++)
        r_state[i] <= ENT_FREE;
    end else begin
      // Allocate, done and commit always touch different entries
      if (i_alloc) begin
        r_state[r_tail] <= ENT_WAIT;
        r_tail          <= r_tail + 1'b1;
      end
      if (i_done0.valid)
        r_state[i_done0.rob_id] <= ENT_DONE;
      if (i_done1.valid)
        r_state[i_done1.rob_id] <= ENT_DONE;
      if (o_commit_valid) begin
        r_state[r_head] <= ENT_FREE;
        r_head          <= r_head + 1'b1;
      end
    end
  end

  // Entry payload
  always_ff @(posedge i_clk) begin
    if (i_alloc)
      r_rd[r_tail] <= i_alloc_rd;
    if (i_done0.valid)
      r_data[i_done0.rob_id] <= i_done0.data;
    if (i_done1.valid)
      r_data[i_done1.rob_id] <= i_done1.data;
  end

  a_done_live : assert property (@(posedge i_clk) disable iff (!i_arst_n)
    (!i_done0.valid || (r_state[i_done0.rob_id] != ENT_FREE)) &&
    (!i_done1.valid || (r_state[i_done1.rob_id] != ENT_FREE)))
    else $error("Done report for a free ROB entry");

  a_alloc_free : assert property (@(posedge i_clk) disable iff (!i_arst_n)
    i_alloc |-> (r_state[r_tail] == ENT_FREE))
    else $error("ROB allocation over live entry %0d", r_tail);

endmodule

// File: source/tile_dispatch_ctrl.sv
`timescale 1ns/10ps

module tile_dispatch_ctrl (
  input  logic                           i_clk,
  input  logic                           i_arst_n,

  input  logic                           i_disp_valid,
  input  tile_pkg::disp_inst_t           i_disp,
  output logic                           o_disp_ready,

  output logic [tile_pkg::REG_W-1:0]     o_rd_addr_a,
  output logic [tile_pkg::REG_W-1:0]     o_rd_addr_b,
  input  logic [tile_pkg::XLEN-1:0]      i_rd_data_a,
  input  logic [tile_pkg::XLEN-1:0]      i_rd_data_b,

  input  logic [tile_pkg::ROB_ID_W-1:0]  i_new_rob_id,

  input  logic                           i_rob_ret,
  input  logic                           i_mul_ret,

  input  tile_pkg::phy_wr_t              i_alu_wr,
  input  tile_pkg::phy_wr_t              i_mul_wr,

  output logic                           o_alu_issue_valid,
  output logic                           o_mul_issue_valid,
  output tile_pkg::issue_t               o_issue
);

  import tile_pkg::*;

  logic [ROB_CRED_W-1:0] r_rob_cred;
  logic                  r_mul_cred;
  logic [REG_NUM-1:0]    r_busy;
  logic [REG_NUM-1:0]    w_busy_nxt;
  logic                  w_is_mul;
  logic                  w_src_busy;
  logic                  w_accept;

  // ---------------------------------------------------------------------
  // Resource check
  // ---------------------------------------------------------------------
  assign w_is_mul   = (i_disp.op == OP_MUL);
  // rs2 is ignored for immediate forms
  assign w_src_busy = r_busy[i_disp.rs1] | (~i_disp.use_imm & r_busy[i_disp.rs2]);

  assign o_disp_ready = (r_rob_cred != '0) & ~w_src_busy & ~r_busy[i_disp.rd] &
                        (r_mul_cred | ~w_is_mul);
  assign w_accept     = i_disp_valid & o_disp_ready;

  // Operand read and unit select
  assign o_rd_addr_a = i_disp.rs1;
  assign o_rd_addr_b = i_disp.rs2;

  assign o_alu_issue_valid = w_accept & ~w_is_mul;
  assign o_mul_issue_valid = w_accept & w_is_mul;

  assign o_issue = '{op:     i_disp.op,
                     rd:     i_disp.rd,
                     rob_id: i_new_rob_id,
                     opa:    i_rd_data_a,
                     opb:    i_disp.use_imm ? i_disp.imm : i_rd_data_b};

  // ---------------------------------------------------------------------
  // Credits and busy table
  // ---------------------------------------------------------------------
  always_comb begin
    w_busy_nxt = r_busy;
    if (i_alu_wr.valid)
      w_busy_nxt[i_alu_wr.rd] = 1'b0;
    if (i_mul_wr.valid)
      w_busy_nxt[i_mul_wr.rd] = 1'b0;
    // x0 never waits on a producer
    if (w_accept && (i_disp.rd != '0))
      w_busy_nxt[i_disp.rd] = 1'b1;
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      r_rob_cred <= ROB_CRED_W'(ROB_SIZE);
      r_mul_cred <= 1'b1;
      r_busy     <= '0;
    end else begin
      r_rob_cred <= r_rob_cred + ROB_CRED_W'(i_rob_ret) - ROB_CRED_W'(w_accept);
      if (i_mul_ret)
        r_mul_cred <= 1'b1;
      else if (o_mul_issue_valid)
        r_mul_cred <= 1'b0;
      r_busy <= w_busy_nxt;
    end
  end

  a_rob_cred_max : assert property (@(posedge i_clk) disable iff (!i_arst_n)
    r_rob_cred <= ROB_CRED_W'(ROB_SIZE))
    else $error("ROB credit above ROB_SIZE: %0d", r_rob_cred);

  a_mul_cred_ret : assert property (@(posedge i_clk) disable iff (!i_arst_n)
    i_mul_ret |-> !r_mul_cred)
    else $error("Multiplier credit returned while already held");

endmodule

// File: source/tile_top.sv
`timescale 1ns/10ps

module tile_top (
  input  logic                  i_clk,
  input  logic                  i_arst_n,

  input  logic                  i_disp_valid,
  input  tile_pkg::disp_inst_t  i_disp,
  output logic                  o_disp_ready,

  output logic                  o_commit_valid,
  output tile_pkg::commit_t     o_commit
);

  import tile_pkg::*;

  logic                w_accept;
  logic [REG_W-1:0]    w_rd_addr_a;
  logic [REG_W-1:0]    w_rd_addr_b;
  logic [XLEN-1:0]     w_rd_data_a;
  logic [XLEN-1:0]     w_rd_data_b;
  logic [ROB_ID_W-1:0] w_new_rob_id;
  logic                w_mul_ret;

  logic                w_alu_issue_valid;
  logic                w_mul_issue_valid;
  issue_t              w_issue;

  phy_wr_t             w_alu_wr;
  phy_wr_t             w_mul_wr;
  done_rpt_t           w_alu_done;
  done_rpt_t           w_mul_done;

  // ROB allocates on every accepted instruction
  assign w_accept = i_disp_valid & o_disp_ready;

  // ---------------------------------------------------------------------
  // Dispatch
  // ---------------------------------------------------------------------
  tile_dispatch_ctrl u_dispatch_ctrl (
    .i_clk             (i_clk),
    .i_arst_n          (i_arst_n),
    .i_disp_valid      (i_disp_valid),
    .i_disp            (i_disp),
    .o_disp_ready      (o_disp_ready),
    .o_rd_addr_a       (w_rd_addr_a),
    .o_rd_addr_b       (w_rd_addr_b),
    .i_rd_data_a       (w_rd_data_a),
    .i_rd_data_b       (w_rd_data_b),
    .i_new_rob_id      (w_new_rob_id),
    .i_rob_ret         (o_commit_valid),
    .i_mul_ret         (w_mul_ret),
    .i_alu_wr          (w_alu_wr),
    .i_mul_wr          (w_mul_wr),
    .o_alu_issue_valid (w_alu_issue_valid),
    .o_mul_issue_valid (w_mul_issue_valid),
    .o_issue           (w_issue)
  );

  // ---------------------------------------------------------------------
  // Execution units
  // ---------------------------------------------------------------------
  tile_alu u_alu (
    .i_clk         (i_clk),
    .i_arst_n      (i_arst_n),
    .i_issue_valid (w_alu_issue_valid),
    .i_issue       (w_issue),
    .o_wr          (w_alu_wr),
    .o_done        (w_alu_done)
  );

  tile_mul u_mul (
    .i_clk         (i_clk),
    .i_arst_n      (i_arst_n),
    .i_issue_valid (w_mul_issue_valid),
    .i_issue       (w_issue),
    .o_wr          (w_mul_wr),
    .o_done        (w_mul_done),
    .o_credit_ret  (w_mul_ret)
  );

  // ---------------------------------------------------------------------
  // Register file and ROB
  // ---------------------------------------------------------------------
  tile_regfile u_regfile (
    .i_clk       (i_clk),
    .i_arst_n    (i_arst_n),
    .i_rd_addr_a (w_rd_addr_a),
    .i_rd_addr_b (w_rd_addr_b),
    .o_rd_data_a (w_rd_data_a),
    .o_rd_data_b (w_rd_data_b),
    .i_wr0       (w_alu_wr),
    .i_wr1       (w_mul_wr)
  );

  tile_rob u_rob (
    .i_clk          (i_clk),
    .i_arst_n       (i_arst_n),
    .i_alloc        (w_accept),
    .i_alloc_rd     (i_disp.rd),
    .o_new_rob_id   (w_new_rob_id),
    .i_done0        (w_alu_done),
    .i_done1        (w_mul_done),
    .o_commit_valid (o_commit_valid),
    .o_commit       (o_commit)
  );

endmodule

// File: verif/tb_tile.sv
`timescale 1ns/10ps

module tb_tile;

  import tile_pkg::*;

  localparam int CLK_HALF   = 4;
  // Directed plus random instructions
  localparam int INST_COUNT = 229;
  localparam int TIMEOUT_NS = INST_COUNT * 40 * 8 + 2000;
  localparam int WAIT_LIMIT = 400;

  typedef struct packed {
    logic    is_mul;
    commit_t c;
  } exp_t;

  logic            clk;
  logic            arst_n;
  logic            disp_valid;
  disp_inst_t      disp;
  logic            disp_ready;
  logic            commit_valid;
  commit_t         commit;

  logic [XLEN-1:0] model_regs [REG_NUM];
  exp_t            exp_q [$];
  int              errors;
  int              commits;
  int              stall_cycles;
  int              peak;
  int              mul_open;
  logic            mul_order_chk;

  tile_top tile_top_i (
    .i_clk          (clk),
    .i_arst_n       (arst_n),
    .i_disp_valid   (disp_valid),
    .i_disp         (disp),
    .o_disp_ready   (disp_ready),
    .o_commit_valid (commit_valid),
    .o_commit       (commit)
  );

  always #(CLK_HALF) clk = ~clk;

  initial begin
    #(TIMEOUT_NS);
    $display("Watchdog expired after %0d ns, the run timed out", TIMEOUT_NS);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  // ---------------------------------------------------------------------
  // Reference model and compare tasks
  // ---------------------------------------------------------------------
  function automatic logic [XLEN-1:0] model_result(op_e op, logic [XLEN-1:0] a,
                                                    logic [XLEN-1:0] b);
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      OP_XOR:  return a ^ b;
      OP_SLL:  return a << b[4:0];
      OP_MUL:  return a * b;
      default: return 'x;
    endcase
  endfunction

  function automatic disp_inst_t make_inst(op_e op, int rd, int rs1, int rs2,
                                           logic use_imm, logic [XLEN-1:0] imm);
    return '{op: op, rd: REG_W'(rd), rs1: REG_W'(rs1), rs2: REG_W'(rs2),
             use_imm: use_imm, imm: imm};
  endfunction

  task automatic compare_commit(input string name, input commit_t got, input commit_t want);
    if (got !== want) begin
      errors++;
      $display("Error: %s rd got %h expected %h, data got %h expected %h",
               name, got.rd, want.rd, got.data, want.data);
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic want);
    if (got !== want) begin
      errors++;
      $display("Error: %s got %h expected %h", name, got, want);
    end
  endtask

  // Commit check first, so a same-edge retire is seen before the accept
  always @(posedge clk) begin : monitor
    exp_t            ent;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    if (arst_n) begin
      if (commit_valid) begin
        commits++;
        if (exp_q.size() == 0) begin
          errors++;
          $display("Commit seen at %0t with no instruction outstanding", $time);
        end else begin
          ent = exp_q.pop_front();
          compare_commit("o_commit", commit, ent.c);
          if (ent.is_mul)
            mul_open--;
        end
      end
      if (disp_valid && !disp_ready)
        stall_cycles++;
      if (disp_valid && disp_ready) begin
        if (exp_q.size() >= ROB_SIZE) begin
          errors++;
          $display("Instruction accepted at %0t with the ROB already full", $time);
        end
        if (disp.op == OP_MUL) begin
          if (mul_order_chk && (mul_open != 0)) begin
            errors++;
            $display("Second multiply accepted at %0t before the first retired", $time);
          end
          mul_open++;
        end
        a             = model_regs[disp.rs1];
        b             = disp.use_imm ? disp.imm : model_regs[disp.rs2];
        ent.is_mul    = (disp.op == OP_MUL);
        ent.c.rd      = disp.rd;
        ent.c.data    = model_result(disp.op, a, b);
        if (disp.rd != '0)
          model_regs[disp.rd] = ent.c.data;
        exp_q.push_back(ent);
        if (exp_q.size() > peak)
          peak = exp_q.size();
      end
    end
  end

  // ---------------------------------------------------------------------
  // Driver tasks
  // ---------------------------------------------------------------------
  task automatic dispatch_inst(input disp_inst_t inst);
    int waited;
    waited = 0;
    disp_valid <= 1'b1;
    disp       <= inst;
    @(posedge clk);
    while (!disp_ready && (waited < WAIT_LIMIT)) begin
      waited++;
      @(posedge clk);
    end
    if (!disp_ready) begin
      errors++;
      $display("Dispatch not accepted within %0d cycles", WAIT_LIMIT);
      disp_valid <= 1'b0;
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    disp_valid <= 1'b0;
    // Let the monitor record the last accept first
    @(negedge clk);
    while ((exp_q.size() != 0) && (waited < WAIT_LIMIT)) begin
      @(negedge clk);
      waited++;
    end
    if (exp_q.size() != 0) begin
      errors++;
      $display("%0d expected commits never arrived", exp_q.size());
    end
    @(posedge clk);
  endtask

  // ---------------------------------------------------------------------
  // Directed tests
  // ---------------------------------------------------------------------
  task automatic idle_after_reset();
    @(negedge clk);
    compare_bit("o_disp_ready", disp_ready, 1'b1);
    repeat (6) begin
      @(negedge clk);
      compare_bit("o_commit_valid", commit_valid, 1'b0);
    end
    @(posedge clk);
  endtask

  task automatic imm_op_sweep();
    dispatch_inst(make_inst(OP_ADD, 1, 0, 0, 1'b1, 32'h1234_5678));
    wait_drain();
    dispatch_inst(make_inst(OP_SUB, 2, 1, 0, 1'b1, 32'h0000_0003));
    dispatch_inst(make_inst(OP_AND, 3, 1, 0, 1'b1, 32'h0000_0ff0));
    dispatch_inst(make_inst(OP_OR,  4, 1, 0, 1'b1, 32'h8000_000f));
    dispatch_inst(make_inst(OP_XOR, 5, 1, 0, 1'b1, 32'hffff_ffff));
    dispatch_inst(make_inst(OP_SLL, 6, 1, 0, 1'b1, 32'h0000_0023));
    // x0 write is dropped and the next read sees zero
    dispatch_inst(make_inst(OP_ADD, 0, 1, 0, 1'b1, 32'h0000_0001));
    dispatch_inst(make_inst(OP_ADD, 7, 0, 0, 1'b1, 32'h0000_0000));
    wait_drain();
  endtask

  task automatic dep_chain_stalls();
    int stalls_before;
    stalls_before = stall_cycles;
    dispatch_inst(make_inst(OP_ADD, 9,  1,  2, 1'b0, '0));
    dispatch_inst(make_inst(OP_SUB, 10, 9,  3, 1'b0, '0));
    dispatch_inst(make_inst(OP_XOR, 11, 10, 9, 1'b0, '0));
    dispatch_inst(make_inst(OP_SLL, 12, 11, 4, 1'b0, '0));
    dispatch_inst(make_inst(OP_AND, 9,  12, 5, 1'b0, '0));
    dispatch_inst(make_inst(OP_OR,  13, 9,  6, 1'b0, '0));
    wait_drain();
    if (stall_cycles == stalls_before) begin
      errors++;
      $display("Dependent chain never stalled on a busy register");
    end
  endtask

  task automatic mul_commit_order();
    int stalls_before;
    stalls_before = stall_cycles;
    mul_order_chk = 1'b1;
    dispatch_inst(make_inst(OP_MUL, 14, 1, 0, 1'b1, 32'hffff_fff1));
    dispatch_inst(make_inst(OP_ADD, 2,  3, 0, 1'b1, 32'h0000_0005));
    dispatch_inst(make_inst(OP_XOR, 4,  5, 0, 1'b1, 32'h0f0f_0f0f));
    dispatch_inst(make_inst(OP_OR,  6,  0, 0, 1'b1, 32'h0000_0077));
    dispatch_inst(make_inst(OP_MUL, 15, 2, 0, 1'b1, 32'h0000_0009));
    wait_drain();
    mul_order_chk = 1'b0;
    if (stall_cycles == stalls_before) begin
      errors++;
      $display("Second multiply was never held off by dispatch");
    end
  endtask

  task automatic rob_fill_drain();
    peak = 0;
    dispatch_inst(make_inst(OP_MUL, 14, 1, 0, 1'b1, 32'hffff_ffff));
    for (int i = 0; i < 9; i++)
      dispatch_inst(make_inst(OP_ADD, 2 + i, 1, 0, 1'b1, XLEN'(i * 3 + 1)));
    wait_drain();
    if (peak != ROB_SIZE) begin
      errors++;
      $display("ROB peak occupancy was %0d instead of %0d", peak, ROB_SIZE);
    end
  endtask

  task automatic random_mix();
    disp_inst_t inst;
    for (int i = 0; i < 200; i++) begin
      inst.op      = op_e'(3'($urandom % 7));
      inst.rd      = REG_W'($urandom);
      inst.rs1     = REG_W'($urandom);
      inst.rs2     = REG_W'($urandom);
      inst.use_imm = 1'($urandom);
      inst.imm     = $urandom;
      dispatch_inst(inst);
    end
    wait_drain();
  endtask

  initial begin
    void'($urandom(32'h1295_adb9));
    clk           = 1'b0;
    arst_n        = 1'b0;
    disp_valid    = 1'b0;
    disp          = '0;
    errors        = 0;
    commits       = 0;
    stall_cycles  = 0;
    peak          = 0;
    mul_open      = 0;
    mul_order_chk = 1'b0;
    for (int i = 0; i < REG_NUM; i++)
      model_regs[i] = '0;

    repeat (4) @(posedge clk);
    arst_n <= 1'b1;
    @(posedge clk);

    idle_after_reset();
    imm_op_sweep();
    dep_chain_stalls();
    mul_commit_order();
    rob_fill_drain();
    random_mix();

    repeat (4) @(posedge clk);
    $display("Errors: %0d, commits checked: %0d", errors, commits);
    if (errors == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// File: filelist.f
source/tile_pkg.sv
source/tile_regfile.sv
source/tile_alu.sv
source/tile_mul.sv
source/tile_rob.sv
source/tile_dispatch_ctrl.sv
source/tile_top.sv
verif/tb_tile.sv
